// File: run.sh
#!/bin/sh
# Build and run the tracer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_tracer -o tb_tracer
./obj_dir/tb_tracer > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test passed$" sim.log; then
  exit 0
else
  echo "Simulation did not pass, see sim.log"
  exit 1
fi

// File: src.f
+incdir+.
trace_pkg.sv
trace_stage_ctrl.sv
trace_record_store.sv
trace_retire_order.sv
trace_core_tracer.sv
tb_tracer.sv

// File: tb_tracer_cases.svh
// Each row holds test, pc, instr, compressed, illegal, ex wait, apu, apu rows left,
// write stage, write addr, memory op, memory addr and wb wait

// ALU writes rd in EX
cases[0]  = '{1, 32'h0000_0100, 32'h00a0_0293, 1'b0, 1'b0, 0, 1'b0, 0,
              WR_EX, 5'd5, MEM_NONE, 32'h0, 0};
cases[1]  = '{1, 32'h0000_0104, 32'h0010_0413, 1'b0, 1'b0, 2, 1'b0, 0,
              WR_EX, 5'd8, MEM_NONE, 32'h0, 1};

// Store followed by a load that writes rd in WB
cases[2]  = '{2, 32'h0000_0108, 32'h0051_2023, 1'b0, 1'b0, 0, 1'b0, 0,
              WR_NONE, 5'd0, MEM_STORE, 32'h0000_2000, 0};
cases[3]  = '{2, 32'h0000_010c, 32'h0001_2303, 1'b0, 1'b0, 1, 1'b0, 0,
              WR_WB, 5'd6, MEM_LOAD, 32'h0000_2004, 1};

// Long APU op overtaken by an ALU op
cases[4]  = '{3, 32'h0000_0110, 32'h0223_03b3, 1'b0, 1'b0, 0, 1'b1, 1,
              WR_WB, 5'd7, MEM_NONE, 32'h0, 0};
cases[5]  = '{3, 32'h0000_0114, 32'h0010_0413, 1'b0, 1'b0, 0, 1'b0, 0,
              WR_EX, 5'd8, MEM_NONE, 32'h0, 0};

// MRET and C.EBREAK between neighbors
cases[6]  = '{4, 32'h0000_0118, 32'h0020_0493, 1'b0, 1'b0, 0, 1'b0, 0,
              WR_EX, 5'd9, MEM_NONE, 32'h0, 0};
cases[7]  = '{4, 32'h0000_011c, 32'h3020_0073, 1'b0, 1'b0, 0, 1'b0, 0,
              WR_NONE, 5'd0, MEM_NONE, 32'h0, 0};
cases[8]  = '{4, 32'h0000_0120, 32'h0000_9002, 1'b1, 1'b0, 0, 1'b0, 0,
              WR_NONE, 5'd0, MEM_NONE, 32'h0, 1};
cases[9]  = '{4, 32'h0000_0122, 32'h0030_0513, 1'b0, 1'b0, 0, 1'b0, 0,
              WR_EX, 5'd10, MEM_NONE, 32'h0, 0};

// Illegal row followed by a write to a register other than rd
cases[10] = '{5, 32'h0000_0124, 32'hffff_ffff, 1'b0, 1'b1, 0, 1'b0, 0,
              WR_NONE, 5'd0, MEM_NONE, 32'h0, 0};
cases[11] = '{5, 32'h0000_0128, 32'h0040_0593, 1'b0, 1'b0, 0, 1'b0, 0,
              WR_EX, 5'd12, MEM_NONE, 32'h0, 0};

// Four in flight behind a parked APU op and the fifth one dropped
cases[12] = '{6, 32'h0000_0200, 32'h0223_03b3, 1'b0, 1'b0, 0, 1'b1, 4,
              WR_WB, 5'd7, MEM_NONE, 32'h0, 0};
cases[13] = '{6, 32'h0000_0204, 32'h00a0_0293, 1'b0, 1'b0, 1, 1'b0, 0,
              WR_EX, 5'd5, MEM_NONE, 32'h0, 0};
cases[14] = '{6, 32'h0000_0208, 32'h0010_0413, 1'b0, 1'b0, 0, 1'b0, 0,
              WR_EX, 5'd8, MEM_NONE, 32'h0, 0};
cases[15] = '{6, 32'h0000_020c, 32'h0030_0513, 1'b0, 1'b0, 0, 1'b0, 0,
              WR_EX, 5'd10, MEM_NONE, 32'h0, 0};
cases[16] = '{6, 32'h0000_0210, 32'h0040_0593, 1'b0, 1'b0, 0, 1'b0, 0,
              WR_EX, 5'd11, MEM_NONE, 32'h0, 0};

// File: tb_tracer.sv
`timescale 1ns/10ps

module tb_tracer;

  import trace_pkg::*;

  localparam int unsigned NUM_CASES = 17;

  localparam logic [1:0] WR_NONE = 2'd0;
  localparam logic [1:0] WR_EX   = 2'd1;
  localparam logic [1:0] WR_WB   = 2'd2;
  localparam logic [1:0] MEM_NONE  = 2'd0;
  localparam logic [1:0] MEM_LOAD  = 2'd1;
  localparam logic [1:0] MEM_STORE = 2'd2;

  // One instruction scenario as the core would present it
  typedef struct packed {
    int unsigned test;
    word_t       pc;
    word_t       instr;
    logic        comp;
    logic        ill;
    int unsigned ex_wait;
    logic        apu;
    int unsigned apu_lat;
    logic [1:0]  wr_stage;
    reg_addr_t   wr_addr;
    logic [1:0]  mem_op;
    word_t       mem_addr;
    int unsigned wb_wait;
  } case_t;

  typedef struct packed {
    word_t     pc;
    word_t     instr;
    logic      comp;
    logic      rd_we;
    reg_addr_t rd_addr;
    word_t     rd_data;
    logic      mem;
    logic      mem_we;
    word_t     mem_addr;
    word_t     mem_wdata;
  } exp_t;

  logic      clk_i;
  logic      rst_n;
  logic      id_valid_i;
  logic      is_decoding_i;
  logic      is_illegal_i;
  logic      compressed_i;
  word_t     pc_i;
  word_t     instr_i;
  logic      ex_valid_i;
  logic      ex_reg_we_i;
  reg_addr_t ex_reg_addr_i;
  word_t     ex_reg_wdata_i;
  logic      ex_data_req_i;
  logic      ex_data_gnt_i;
  logic      ex_data_we_i;
  word_t     ex_data_addr_i;
  word_t     ex_data_wdata_i;
  logic      apu_en_i;
  logic      apu_rvalid_i;
  logic      wb_valid_i;
  logic      wb_reg_we_i;
  reg_addr_t wb_reg_addr_i;
  word_t     wb_reg_wdata_i;

  logic      rec_valid_o;
  logic      rec_compressed_o;
  logic      rec_rd_we_o;
  logic      rec_mem_o;
  logic      rec_mem_we_o;
  logic      overflow_o;
  word_t     rec_pc_o;
  word_t     rec_instr_o;
  word_t     rec_rd_wdata_o;
  word_t     rec_mem_addr_o;
  word_t     rec_mem_wdata_o;
  cycle_t    rec_cycle_o;
  reg_addr_t rec_rd_addr_o;

  case_t       cases [NUM_CASES];
  exp_t        exp_q [$];
  int unsigned err_count;
  logic        exp_ovf;
  logic        timed_out;
  logic        first_rec;
  cycle_t      last_cycle;
  // Pending APU operation parked in EX-delay
  logic        apu_pending;
  int unsigned apu_left;
  case_t       apu_row;
  word_t       apu_wdata;

  trace_core_tracer dut_i (.*);

  always #2 clk_i = ~clk_i;

  task automatic load_cases();
    `include "tb_tracer_cases.svh"
  endtask

  // ------------------------------
  // Compare tasks
  // ------------------------------

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_reg(string name, reg_addr_t got, reg_addr_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      err_count++;
    end
  endtask

  // Record monitor samples at the falling edge where outputs are stable
  always @(negedge clk_i) begin
    exp_t e;
    if (rst_n && rec_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected record at %0t ns with pc %h", $time, rec_pc_o);
        err_count++;
      end else begin
        e = exp_q.pop_front();
        check_word("rec pc", rec_pc_o, e.pc);
        check_word("rec instr", rec_instr_o, e.instr);
        check_flag("rec compressed", rec_compressed_o, e.comp);
        check_flag("rec rd we", rec_rd_we_o, e.rd_we);
        check_reg("rec rd addr", rec_rd_addr_o, e.rd_addr);
        if (e.rd_we) begin
          check_word("rec rd data", rec_rd_wdata_o, e.rd_data);
        end
        check_flag("rec mem", rec_mem_o, e.mem);
        if (e.mem) begin
          check_flag("rec mem we", rec_mem_we_o, e.mem_we);
          check_word("rec mem addr", rec_mem_addr_o, e.mem_addr);
          check_word("rec mem wdata", rec_mem_wdata_o, e.mem_wdata);
        end
        if (!first_rec) begin
          check_flag("cycle increasing", rec_cycle_o > last_cycle, 1'b1);
        end
        first_rec  = 1'b0;
        last_cycle = rec_cycle_o;
      end
    end
  end

  // ------------------------------
  // Core-side drivers
  // ------------------------------

  task automatic next_cycle();
    @(posedge clk_i);
    @(negedge clk_i);
  endtask

  task automatic clear_inputs();
    id_valid_i      = 1'b0;
    is_decoding_i   = 1'b0;
    is_illegal_i    = 1'b0;
    compressed_i    = 1'b0;
    pc_i            = '0;
    instr_i         = '0;
    ex_valid_i      = 1'b0;
    ex_reg_we_i     = 1'b0;
    ex_reg_addr_i   = '0;
    ex_reg_wdata_i  = '0;
    ex_data_req_i   = 1'b0;
    ex_data_gnt_i   = 1'b0;
    ex_data_we_i    = 1'b0;
    ex_data_addr_i  = '0;
    ex_data_wdata_i = '0;
    apu_en_i        = 1'b0;
    apu_rvalid_i    = 1'b0;
    wb_valid_i      = 1'b0;
    wb_reg_we_i     = 1'b0;
    wb_reg_addr_i   = '0;
    wb_reg_wdata_i  = '0;
  endtask

  // Expected record from the row with rd kept only on a non-zero rd match
  task automatic push_expected(case_t r, word_t wdata, word_t mdata);
    exp_t e;
    e.pc        = r.pc;
    e.instr     = r.instr;
    e.comp      = r.comp;
    e.rd_addr   = r.instr[11:7];
    e.rd_we     = (r.wr_stage != WR_NONE) && (r.wr_addr == e.rd_addr) && (r.wr_addr != '0);
    e.rd_data   = wdata;
    e.mem       = (r.mem_op != MEM_NONE);
    e.mem_we    = (r.mem_op == MEM_STORE);
    e.mem_addr  = r.mem_addr;
    e.mem_wdata = e.mem_we ? mdata : '0;
    exp_q.push_back(e);
  endtask

  task automatic drive_wb_write(case_t r, word_t wdata);
    wb_valid_i = 1'b1;
    if (r.wr_stage == WR_WB) begin
      wb_reg_we_i    = 1'b1;
      wb_reg_addr_i  = r.wr_addr;
      wb_reg_wdata_i = wdata;
    end
    next_cycle();
    clear_inputs();
    // WB-delay retires on this edge
    next_cycle();
  endtask

  task automatic drive_row(case_t r);
    word_t wdata;
    word_t mdata;
    wdata = $urandom;
    mdata = $urandom;
    id_valid_i    = 1'b1;
    is_decoding_i = 1'b1;
    is_illegal_i  = r.ill;
    pc_i          = r.pc;
    instr_i       = r.instr;
    compressed_i  = r.comp;
    if (!r.ill) begin
      if (exp_q.size() < int'(TRACE_DEPTH)) begin
        push_expected(r, wdata, mdata);
      end else begin
        exp_ovf = 1'b1;
      end
    end
    next_cycle();
    clear_inputs();
    repeat (r.ex_wait) next_cycle();
    ex_valid_i = 1'b1;
    apu_en_i   = r.apu;
    if (r.wr_stage == WR_EX) begin
      ex_reg_we_i    = 1'b1;
      ex_reg_addr_i  = r.wr_addr;
      ex_reg_wdata_i = wdata;
    end
    if (r.mem_op != MEM_NONE) begin
      ex_data_req_i   = 1'b1;
      ex_data_gnt_i   = 1'b1;
      ex_data_we_i    = (r.mem_op == MEM_STORE);
      ex_data_addr_i  = r.mem_addr;
      ex_data_wdata_i = mdata;
    end
    next_cycle();
    clear_inputs();
    if (r.apu) begin
      apu_pending = 1'b1;
      apu_left    = r.apu_lat;
      apu_row     = r;
      apu_wdata   = wdata;
    end else begin
      repeat (r.wb_wait) next_cycle();
      drive_wb_write(r, wdata);
    end
  endtask

  task automatic finish_apu();
    repeat (2) next_cycle();
    apu_rvalid_i = 1'b1;
    next_cycle();
    apu_rvalid_i = 1'b0;
    drive_wb_write(apu_row, apu_wdata);
    apu_pending = 1'b0;
  endtask

  task automatic wait_records(int unsigned test);
    int unsigned n;
    n = 0;
    while (exp_q.size() != 0 && n < 100) begin
      next_cycle();
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout: records of test %0d did not appear within 100 cycles", test);
      timed_out = 1'b1;
    end else begin
      // Room for a stray extra record
      repeat (4) next_cycle();
    end
  endtask

  initial begin
    int unsigned test_err;
    int unsigned n_pass;
    int unsigned n_fail;
    void'($urandom(50));
    clk_i       = 1'b0;
    rst_n       = 1'b0;
    err_count   = 0;
    exp_ovf     = 1'b0;
    timed_out   = 1'b0;
    first_rec   = 1'b1;
    last_cycle  = '0;
    apu_pending = 1'b0;
    apu_left    = 0;
    apu_wdata   = '0;
    n_pass      = 0;
    n_fail      = 0;
    clear_inputs();
    load_cases();
    apu_row = cases[0];
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n = 1'b1;
    next_cycle();

    test_err = 0;
    for (int i = 0; i < int'(NUM_CASES); i++) begin
      drive_row(cases[i]);
      if (apu_pending && !cases[i].apu) begin
        apu_left--;
        if (apu_left == 0) begin
          finish_apu();
        end
      end
      if (i == int'(NUM_CASES) - 1 || cases[i + 1].test != cases[i].test) begin
        wait_records(cases[i].test);
        check_flag("overflow", overflow_o, exp_ovf);
        if (err_count == test_err && !timed_out) begin
          $display("Test %0d: ok", cases[i].test);
          n_pass++;
        end else begin
          $display("Test %0d: FAILED with %0d errors", cases[i].test, err_count - test_err);
          n_fail++;
        end
        test_err = err_count;
        if (timed_out) begin
          break;
        end
      end
    end

    $display("%0d tests passed, %0d failed, %0d check errors", n_pass, n_fail, err_count);
    if (err_count == 0 && !timed_out) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: trace_core_tracer.sv
`timescale 1ns/10ps

module trace_core_tracer (
  input  logic                 clk_i,
  input  logic                 rst_n,
  // Decode
  input  logic                 id_valid_i,
  input  logic                 is_decoding_i,
  input  logic                 is_illegal_i,
  input  trace_pkg::word_t     pc_i,
  input  trace_pkg::word_t     instr_i,
  input  logic                 compressed_i,
  // Execute
  input  logic                 ex_valid_i,
  input  logic                 ex_reg_we_i,
  input  trace_pkg::reg_addr_t ex_reg_addr_i,
  input  trace_pkg::word_t     ex_reg_wdata_i,
  // Data memory
  input  logic                 ex_data_req_i,
  input  logic                 ex_data_gnt_i,
  input  logic                 ex_data_we_i,
  input  trace_pkg::word_t     ex_data_addr_i,
  input  trace_pkg::word_t     ex_data_wdata_i,
  // APU
  input  logic                 apu_en_i,
  input  logic                 apu_rvalid_i,
  // Writeback
  input  logic                 wb_valid_i,
  input  logic                 wb_reg_we_i,
  input  trace_pkg::reg_addr_t wb_reg_addr_i,
  input  trace_pkg::word_t     wb_reg_wdata_i,
  // Retire record
  output logic                 rec_valid_o,
  output trace_pkg::word_t     rec_pc_o,
  output trace_pkg::word_t     rec_instr_o,
  output logic                 rec_compressed_o,
  output trace_pkg::cycle_t    rec_cycle_o,
  output logic                 rec_rd_we_o,
  output trace_pkg::reg_addr_t rec_rd_addr_o,
  output trace_pkg::word_t     rec_rd_wdata_o,
  output logic                 rec_mem_o,
  output logic                 rec_mem_we_o,
  output trace_pkg::word_t     rec_mem_addr_o,
  output trace_pkg::word_t     rec_mem_wdata_o,
  output logic                 overflow_o
);

  import trace_pkg::*;

  logic issue;
  tag_t issue_tag;
  logic ex_wr;
  logic wb_wr;
  tag_t wb_wr_tag;
  logic mem_wr;
  tag_t ex_tag;
  logic retire_wb;
  tag_t retire_wb_tag;
  logic retire_wbd;
  tag_t retire_wbd_tag;
  logic release_rec;
  tag_t head_tag;

  // ------------------------------
  // Stage tracking
  // ------------------------------

  trace_stage_ctrl u_ctrl (
    .clk_i            (clk_i),
    .rst_n            (rst_n),
    .instr_i          (instr_i),
    .compressed_i     (compressed_i),
    .id_valid_i       (id_valid_i),
    .is_decoding_i    (is_decoding_i),
    .is_illegal_i     (is_illegal_i),
    .ex_valid_i       (ex_valid_i),
    .apu_en_i         (apu_en_i),
    .apu_rvalid_i     (apu_rvalid_i),
    .wb_valid_i       (wb_valid_i),
    .ex_reg_we_i      (ex_reg_we_i),
    .wb_reg_we_i      (wb_reg_we_i),
    .ex_data_req_i    (ex_data_req_i),
    .ex_data_gnt_i    (ex_data_gnt_i),
    .release_i        (release_rec),
    .issue_o          (issue),
    .issue_tag_o      (issue_tag),
    .ex_wr_o          (ex_wr),
    .wb_wr_o          (wb_wr),
    .wb_wr_tag_o      (wb_wr_tag),
    .mem_wr_o         (mem_wr),
    .ex_tag_o         (ex_tag),
    .retire_wb_o      (retire_wb),
    .retire_wb_tag_o  (retire_wb_tag),
    .retire_wbd_o     (retire_wbd),
    .retire_wbd_tag_o (retire_wbd_tag),
    .overflow_o       (overflow_o)
  );

  // ------------------------------
  // Record capture and release
  // ------------------------------

  trace_record_store u_store (
    .clk_i            (clk_i),
    .rst_n            (rst_n),
    .issue_i          (issue),
    .issue_tag_i      (issue_tag),
    .pc_i             (pc_i),
    .instr_i          (instr_i),
    .compressed_i     (compressed_i),
    .ex_wr_i          (ex_wr),
    .ex_tag_i         (ex_tag),
    .ex_reg_addr_i    (ex_reg_addr_i),
    .ex_reg_wdata_i   (ex_reg_wdata_i),
    .wb_wr_i          (wb_wr),
    .wb_wr_tag_i      (wb_wr_tag),
    .wb_reg_addr_i    (wb_reg_addr_i),
    .wb_reg_wdata_i   (wb_reg_wdata_i),
    .mem_wr_i         (mem_wr),
    .ex_data_we_i     (ex_data_we_i),
    .ex_data_addr_i   (ex_data_addr_i),
    .ex_data_wdata_i  (ex_data_wdata_i),
    .head_tag_i       (head_tag),
    .rec_pc_o         (rec_pc_o),
    .rec_instr_o      (rec_instr_o),
    .rec_compressed_o (rec_compressed_o),
    .rec_cycle_o      (rec_cycle_o),
    .rec_rd_we_o      (rec_rd_we_o),
    .rec_rd_addr_o    (rec_rd_addr_o),
    .rec_rd_wdata_o   (rec_rd_wdata_o),
    .rec_mem_o        (rec_mem_o),
    .rec_mem_we_o     (rec_mem_we_o),
    .rec_mem_addr_o   (rec_mem_addr_o),
    .rec_mem_wdata_o  (rec_mem_wdata_o)
  );

  trace_retire_order u_order (
    .clk_i            (clk_i),
    .rst_n            (rst_n),
    .retire_wb_i      (retire_wb),
    .retire_wb_tag_i  (retire_wb_tag),
    .retire_wbd_i     (retire_wbd),
    .retire_wbd_tag_i (retire_wbd_tag),
    .head_tag_o       (head_tag),
    .release_o        (release_rec),
    .rec_valid_o      (rec_valid_o)
  );

endmodule

// File: trace_pkg.sv
package trace_pkg;

  // ------------------------------
  // Widths
  // ------------------------------

  // Data word, used for PC, encoding, register and memory values
  typedef logic [31:0] word_t;

  // Integer register address
  typedef logic [4:0] reg_addr_t;

  // Free-running cycle count captured at issue
  typedef logic [31:0] cycle_t;

  // ------------------------------
  // Capacity
  // ------------------------------

  localparam int unsigned TRACE_DEPTH = 4;
  localparam int unsigned TAG_W = $clog2(TRACE_DEPTH);

  // Tracking slot index, program order modulo the capacity
  typedef logic [TAG_W-1:0] tag_t;

  // In-flight count, needs one more bit to hold a full tracer
  typedef logic [TAG_W:0] count_t;

  localparam count_t TRACE_FULL = count_t'(TRACE_DEPTH);

  // ------------------------------
  // Encodings that retire through WB-delay
  // ------------------------------

  localparam word_t INSN_MRET = 32'h3020_0073;
  localparam word_t INSN_URET = 32'h0020_0073;
  localparam word_t INSN_EBREAK = 32'h0010_0073;
  localparam logic [15:0] INSN_C_EBREAK = 16'h9002;

  // Stage that takes a WB-side register write
  typedef enum logic [1:0] {
    WB_TGT_NONE,
    WB_TGT_EXD,
    WB_TGT_WB
  } wb_target_e;

  // Tracking state of one pipeline stage
  typedef enum logic [1:0] {
    STAGE_EMPTY,
    STAGE_HOLD,
    STAGE_DONE
  } stage_e;

endpackage

// File: trace_record_store.sv
`timescale 1ns/10ps

module trace_record_store (
  input  logic                 clk_i,
  input  logic                 rst_n,
  input  logic                 issue_i,
  input  trace_pkg::tag_t      issue_tag_i,
  input  trace_pkg::word_t     pc_i,
  input  trace_pkg::word_t     instr_i,
  input  logic                 compressed_i,
  input  logic                 ex_wr_i,
  input  trace_pkg::tag_t      ex_tag_i,
  input  trace_pkg::reg_addr_t ex_reg_addr_i,
  input  trace_pkg::word_t     ex_reg_wdata_i,
  input  logic                 wb_wr_i,
  input  trace_pkg::tag_t      wb_wr_tag_i,
  input  trace_pkg::reg_addr_t wb_reg_addr_i,
  input  trace_pkg::word_t     wb_reg_wdata_i,
  input  logic                 mem_wr_i,
  input  logic                 ex_data_we_i,
  input  trace_pkg::word_t     ex_data_addr_i,
  input  trace_pkg::word_t     ex_data_wdata_i,
  input  trace_pkg::tag_t      head_tag_i,
  output trace_pkg::word_t     rec_pc_o,
  output trace_pkg::word_t     rec_instr_o,
  output logic                 rec_compressed_o,
  output trace_pkg::cycle_t    rec_cycle_o,
  output logic                 rec_rd_we_o,
  output trace_pkg::reg_addr_t rec_rd_addr_o,
  output trace_pkg::word_t     rec_rd_wdata_o,
  output logic                 rec_mem_o,
  output logic                 rec_mem_we_o,
  output trace_pkg::word_t     rec_mem_addr_o,
  output trace_pkg::word_t     rec_mem_wdata_o
);

  import trace_pkg::*;

  cycle_t cycle_q;

  // One record per tag
  word_t  pc_q        [TRACE_DEPTH];
  word_t  instr_q     [TRACE_DEPTH];
  logic   comp_q      [TRACE_DEPTH];
  cycle_t icycle_q    [TRACE_DEPTH];
  logic   rd_we_q     [TRACE_DEPTH];
  word_t  rd_wdata_q  [TRACE_DEPTH];
  logic   mem_q       [TRACE_DEPTH];
  logic   mem_we_q    [TRACE_DEPTH];
  word_t  mem_addr_q  [TRACE_DEPTH];
  word_t  mem_wdata_q [TRACE_DEPTH];

  // Write counts only when it hits the rd field, x0 never does
  function automatic logic rd_hit(word_t instr, reg_addr_t addr);
    return (addr != '0) && (addr == instr[11:7]);
  endfunction

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + cycle_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    for (int t = 0; t < TRACE_DEPTH; t++) begin
      if (issue_i && issue_tag_i == tag_t'(t)) begin
        pc_q[t]     <= pc_i;
        instr_q[t]  <= instr_i;
        comp_q[t]   <= compressed_i;
        icycle_q[t] <= cycle_q;
        rd_we_q[t]  <= 1'b0;
        mem_q[t]    <= 1'b0;
      end else begin
        // WB write comes last so it wins over an EX write in the same cycle
        if (ex_wr_i && ex_tag_i == tag_t'(t) && rd_hit(instr_q[t], ex_reg_addr_i)) begin
          rd_we_q[t]    <= 1'b1;
          rd_wdata_q[t] <= ex_reg_wdata_i;
        end
        if (wb_wr_i && wb_wr_tag_i == tag_t'(t) && rd_hit(instr_q[t], wb_reg_addr_i)) begin
          rd_we_q[t]    <= 1'b1;
          rd_wdata_q[t] <= wb_reg_wdata_i;
        end
        if (mem_wr_i && ex_tag_i == tag_t'(t)) begin
          mem_q[t]       <= 1'b1;
          mem_we_q[t]    <= ex_data_we_i;
          mem_addr_q[t]  <= ex_data_addr_i;
          mem_wdata_q[t] <= ex_data_we_i ? ex_data_wdata_i : '0;
        end
      end
    end
  end

  // ------------------------------
  // Record read at the retire head
  // ------------------------------

  assign rec_pc_o         = pc_q[head_tag_i];
  assign rec_instr_o      = instr_q[head_tag_i];
  assign rec_compressed_o = comp_q[head_tag_i];
  assign rec_cycle_o      = icycle_q[head_tag_i];
  assign rec_rd_we_o      = rd_we_q[head_tag_i];
  assign rec_rd_addr_o    = instr_q[head_tag_i][11:7];
  assign rec_rd_wdata_o   = rd_wdata_q[head_tag_i];
  assign rec_mem_o        = mem_q[head_tag_i];
  assign rec_mem_we_o     = mem_we_q[head_tag_i];
  assign rec_mem_addr_o   = mem_addr_q[head_tag_i];
  assign rec_mem_wdata_o  = mem_wdata_q[head_tag_i];

endmodule

// File: trace_retire_order.sv
`timescale 1ns/10ps

module trace_retire_order (
  input  logic            clk_i,
  input  logic            rst_n,
  input  logic            retire_wb_i,
  input  trace_pkg::tag_t retire_wb_tag_i,
  input  logic            retire_wbd_i,
  input  trace_pkg::tag_t retire_wbd_tag_i,
  output trace_pkg::tag_t head_tag_o,
  output logic            release_o,
  output logic            rec_valid_o
);

  import trace_pkg::*;

  logic done_q [TRACE_DEPTH];
  tag_t head_q;
  logic rec_valid_q;

  // Oldest entry has retired, hand it out
  assign release_o = done_q[head_q];

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      for (int t = 0; t < TRACE_DEPTH; t++) begin
        done_q[t] <= 1'b0;
      end
      head_q      <= '0;
      rec_valid_q <= 1'b0;
    end else begin
      rec_valid_q <= release_o;

      // Head stays put while its record is on the outputs
      if (rec_valid_q) begin
        head_q <= head_q + tag_t'(1);
      end

      // WB and WB-delay may both retire in one cycle
      for (int t = 0; t < TRACE_DEPTH; t++) begin
        if ((retire_wb_i && retire_wb_tag_i == tag_t'(t)) ||
            (retire_wbd_i && retire_wbd_tag_i == tag_t'(t))) begin
          done_q[t] <= 1'b1;
        end else if (release_o && head_q == tag_t'(t)) begin
          done_q[t] <= 1'b0;
        end
      end
    end
  end

  assign head_tag_o  = head_q;
  assign rec_valid_o = rec_valid_q;

endmodule

// File: trace_stage_ctrl.sv
`timescale 1ns/10ps

module trace_stage_ctrl (
  input  logic             clk_i,
  input  logic             rst_n,
  input  trace_pkg::word_t instr_i,
  input  logic             compressed_i,
  input  logic             id_valid_i,
  input  logic             is_decoding_i,
  input  logic             is_illegal_i,
  input  logic             ex_valid_i,
  input  logic             apu_en_i,
  input  logic             apu_rvalid_i,
  input  logic             wb_valid_i,
  input  logic             ex_reg_we_i,
  input  logic             wb_reg_we_i,
  input  logic             ex_data_req_i,
  input  logic             ex_data_gnt_i,
  input  logic             release_i,
  output logic             issue_o,
  output trace_pkg::tag_t  issue_tag_o,
  output logic             ex_wr_o,
  output logic             wb_wr_o,
  output trace_pkg::tag_t  wb_wr_tag_o,
  output logic             mem_wr_o,
  output trace_pkg::tag_t  ex_tag_o,
  output logic             retire_wb_o,
  output trace_pkg::tag_t  retire_wb_tag_o,
  output logic             retire_wbd_o,
  output trace_pkg::tag_t  retire_wbd_tag_o,
  output logic             overflow_o
);

  import trace_pkg::*;

  stage_e ex_st_q;
  stage_e exd_st_q;
  stage_e wb_st_q;
  stage_e wbd_st_q;
  tag_t   ex_tag_q;
  tag_t   exd_tag_q;
  tag_t   wb_tag_q;
  tag_t   wbd_tag_q;
  logic   exd_apu_q;
  logic   dly_q [TRACE_DEPTH];
  tag_t   next_tag_q;
  count_t count_q;
  logic   overflow_q;

  logic       ex_occ;
  logic       exd_occ;
  logic       wb_occ;
  logic       issue;
  logic       issue_ok;
  logic       is_dly;
  logic       wbd_retire;
  logic       wb_leave;
  logic       wb_to_wbd;
  logic       wb_retire;
  logic       exd_to_wb;
  logic       ex_leave;
  logic       ex_apu_wait;
  logic       ex_to_exd;
  logic       ex_to_wb;
  wb_target_e wb_tgt;

  assign ex_occ  = (ex_st_q != STAGE_EMPTY);
  assign exd_occ = (exd_st_q != STAGE_EMPTY);
  assign wb_occ  = (wb_st_q != STAGE_EMPTY);

  // New legal instruction, dropped when the tracer is full
  assign issue    = id_valid_i && is_decoding_i && !is_illegal_i;
  assign issue_ok = issue && (count_q != TRACE_FULL);

  // MRET, URET and EBREAK take one extra cycle before they retire
  assign is_dly = compressed_i ? (instr_i[15:0] == INSN_C_EBREAK)
                               : (instr_i == INSN_MRET || instr_i == INSN_URET ||
                                  instr_i == INSN_EBREAK);

  // ------------------------------
  // Stage moves
  // ------------------------------

  // WB-delay always retires on the next edge
  assign wbd_retire = (wbd_st_q == STAGE_DONE);

  assign wb_leave  = wb_occ && wb_valid_i;
  assign wb_to_wbd = wb_leave && dly_q[wb_tag_q];
  assign wb_retire = wb_leave && !dly_q[wb_tag_q];

  // Non-APU entries in EX-delay move on without waiting
  assign exd_to_wb = exd_occ && (apu_rvalid_i || !exd_apu_q);

  assign ex_leave    = ex_occ && ex_valid_i;
  assign ex_apu_wait = apu_en_i && !apu_rvalid_i;
  // WB input is taken by EX-delay, so EX parks there too
  assign ex_to_exd   = ex_leave && (ex_apu_wait || exd_to_wb);
  assign ex_to_wb    = ex_leave && !ex_to_exd;

  // A WB-side write belongs to the older of EX-delay and WB
  always_comb begin
    if (exd_occ) begin
      wb_tgt = WB_TGT_EXD;
    end else if (wb_occ) begin
      wb_tgt = WB_TGT_WB;
    end else begin
      wb_tgt = WB_TGT_NONE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      ex_st_q    <= STAGE_EMPTY;
      exd_st_q   <= STAGE_EMPTY;
      wb_st_q    <= STAGE_EMPTY;
      wbd_st_q   <= STAGE_EMPTY;
      ex_tag_q   <= '0;
      exd_tag_q  <= '0;
      wb_tag_q   <= '0;
      wbd_tag_q  <= '0;
      exd_apu_q  <= 1'b0;
      next_tag_q <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      // EX
      if (issue_ok) begin
        ex_st_q  <= STAGE_HOLD;
        ex_tag_q <= next_tag_q;
      end else if (ex_leave) begin
        ex_st_q <= STAGE_EMPTY;
      end

      // EX-delay
      if (ex_to_exd) begin
        exd_st_q  <= STAGE_HOLD;
        exd_tag_q <= ex_tag_q;
        exd_apu_q <= ex_apu_wait;
      end else if (exd_to_wb) begin
        exd_st_q <= STAGE_EMPTY;
      end

      // WB
      if (ex_to_wb) begin
        wb_st_q  <= STAGE_HOLD;
        wb_tag_q <= ex_tag_q;
      end else if (exd_to_wb) begin
        wb_st_q  <= STAGE_HOLD;
        wb_tag_q <= exd_tag_q;
      end else if (wb_leave) begin
        wb_st_q <= STAGE_EMPTY;
      end

      // WB-delay
      if (wb_to_wbd) begin
        wbd_st_q  <= STAGE_DONE;
        wbd_tag_q <= wb_tag_q;
      end else if (wbd_retire) begin
        wbd_st_q <= STAGE_EMPTY;
      end

      if (issue_ok) begin
        next_tag_q <= next_tag_q + tag_t'(1);
      end

      case ({issue_ok, release_i})
        2'b10:   count_q <= count_q + count_t'(1);
        2'b01:   count_q <= count_q - count_t'(1);
        default: count_q <= count_q;
      endcase

      // Sticky until reset
      if (issue && !issue_ok) begin
        overflow_q <= 1'b1;
      end
    end
  end

  // Delayed-retire flag per tag, looked up once the entry reaches WB
  always_ff @(posedge clk_i) begin
    if (issue_ok) begin
      dly_q[next_tag_q] <= is_dly;
    end
  end

  assign issue_o     = issue_ok;
  assign issue_tag_o = next_tag_q;

  assign ex_wr_o  = ex_occ && ex_reg_we_i;
  assign mem_wr_o = ex_occ && ex_data_req_i && ex_data_gnt_i;
  assign ex_tag_o = ex_tag_q;

  assign wb_wr_o     = wb_reg_we_i && (wb_tgt != WB_TGT_NONE);
  assign wb_wr_tag_o = (wb_tgt == WB_TGT_EXD) ? exd_tag_q : wb_tag_q;

  assign retire_wb_o      = wb_retire;
  assign retire_wb_tag_o  = wb_tag_q;
  assign retire_wbd_o     = wbd_retire;
  assign retire_wbd_tag_o = wbd_tag_q;

  assign overflow_o = overflow_q;

endmodule
